//--- flist.f
hdl/axi_lite_pkg.sv
hdl/link_pkg.sv
hdl/ll_transmit.sv
hdl/ll_receive.sv
hdl/phy_framer.sv
hdl/axi_lite_link_master.sv
verification/tb_axi_lite_link_master.sv

//--- Makefile
# Verilator flow for the AXI-lite link master and its testbench.
# Override any variable on the command line, e.g. make sim BUILD_DIR=obj

VERILATOR ?= verilator
TOP       ?= tb_axi_lite_link_master
BUILD_DIR ?= build
SEED_ARGS ?= +verilator+seed+65

FLIST   := flist.f
SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The testbench ends a failing run with $$fatal, so the exit status carries the result
sim: $(BIN)
	$(BIN) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_axi_lite_link_master.sv
/*
  Testbench for the AXI-lite link master. A far-end model closes the link,
  random user traffic runs on all five channels, and each transfer is
  checked against expected-order queues kept in the model.
*/

`timescale 1ns/10ps

module tb_axi_lite_link_master;

  localparam int n_req        = 40;
  localparam int n_resp       = 40;
  localparam int r_depth      = 8;
  localparam int b_depth      = 8;
  localparam int hold_cycles  = 120;
  localparam int limit_cycles = 200 * (3 * n_req + 2 * n_resp) + hold_cycles;
  // Pop to credit bit on tx_phy, receive credit register then framer register
  localparam int credit_lag   = 2;

  // Channel order in the arrays is AR, AW, W
  localparam int init_credit_val [3] = '{3, 2, 4};
  localparam int credit_off [3] = '{link_pkg::rx_ar_credit_o, link_pkg::rx_aw_credit_o,
                                    link_pkg::rx_w_credit_o};

  logic                              clk_wr;
  logic                              rst;
  logic                              tx_online;
  logic                              rx_online;
  link_pkg::credit_t                 init_ar_credit;
  link_pkg::credit_t                 init_aw_credit;
  link_pkg::credit_t                 init_w_credit;
  logic [link_pkg::tx_word_w-1:0]    tx_phy;
  logic [link_pkg::rx_word_w-1:0]    rx_phy;
  logic [31:0]                       user_araddr;
  logic                              user_arvalid;
  logic                              user_arready;
  logic [31:0]                       user_awaddr;
  logic                              user_awvalid;
  logic                              user_awready;
  logic [31:0]                       user_wdata;
  logic [3:0]                        user_wstrb;
  logic                              user_wvalid;
  logic                              user_wready;
  logic [31:0]                       user_rdata;
  logic [1:0]                        user_rresp;
  logic                              user_rvalid;
  logic                              user_rready;
  logic [1:0]                        user_bresp;
  logic                              user_bvalid;
  logic                              user_bready;

  integer      seed = 65;
  logic        stim_on;
  logic        hold_credit;
  int          acc [3];
  int          pushes [3];
  int          owed [3];
  int          returned [3];
  int          r_inj;
  int          b_inj;
  int          r_pops;
  int          b_pops;
  int          r_credits;
  int          b_credits;
  logic [31:0] ar_exp [$];
  logic [31:0] aw_exp [$];
  logic [35:0] w_exp [$];
  logic [31:0] r_data_exp [$];
  logic [1:0]  r_resp_exp [$];
  logic [1:0]  b_exp [$];

  axi_lite_link_master #(.R_DEPTH(r_depth), .B_DEPTH(b_depth)) uut (.*);

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic random_bit();
    return 1'($random(seed));
  endfunction

  function automatic logic run_complete();
    return pushes[0] == n_req && pushes[1] == n_req && pushes[2] == n_req &&
           r_pops == n_resp && b_pops == n_resp;
  endfunction

  initial begin
    clk_wr = 1'b0;
    forever #20 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Far-end model and user traffic, all sampled before the edge updates

  always @(posedge clk_wr) begin : link_model
    logic [link_pkg::rx_word_w-1:0] word;
    logic [2:0]                     req_push;
    axi_lite_pkg::r_payload_t       rp;
    word = '0;
    req_push = {tx_phy[link_pkg::tx_w_push_o], tx_phy[link_pkg::tx_aw_push_o],
                tx_phy[link_pkg::tx_ar_push_o]};
    // Idle link right after reset
    if (!rst && !tx_online) begin
      check_equal("tx_phy push and credit bits", 64'({req_push,
                  tx_phy[link_pkg::tx_r_credit_o], tx_phy[link_pkg::tx_b_credit_o]}), 64'(0));
      check_equal("user_rvalid", 64'(user_rvalid), 64'(0));
      check_equal("user_bvalid", 64'(user_bvalid), 64'(0));
      check_equal("request ready bits", 64'({user_arready, user_awready, user_wready}),
                  64'(3'b111));
    end
    if (req_push[0]) begin
      if (ar_exp.size() == 0) report_failure("AR push on tx_phy without an accepted request");
      else check_equal("tx_phy ar payload", 64'(tx_phy[link_pkg::tx_ar_data_o +: 32]),
                       64'(ar_exp.pop_front()));
    end
    if (req_push[1]) begin
      if (aw_exp.size() == 0) report_failure("AW push on tx_phy without an accepted request");
      else check_equal("tx_phy aw payload", 64'(tx_phy[link_pkg::tx_aw_data_o +: 32]),
                       64'(aw_exp.pop_front()));
    end
    if (req_push[2]) begin
      if (w_exp.size() == 0) report_failure("W push on tx_phy without an accepted request");
      else check_equal("tx_phy w payload", 64'(tx_phy[link_pkg::tx_w_data_o +: 36]),
                       64'(w_exp.pop_front()));
    end
    for (int i = 0; i < 3; i++) begin
      if (req_push[i]) begin
        pushes[i]++;
        owed[i]++;
        if (pushes[i] > init_credit_val[i] + returned[i]) begin
          report_failure("A request channel pushed beyond its credit");
        end
      end
      if (!hold_credit && owed[i] > 0 && random_bit()) begin
        word[credit_off[i]] = 1'b1;
        owed[i]--;
        returned[i]++;
      end
    end
    // Response credits come back only for earlier handshakes
    if (tx_phy[link_pkg::tx_r_credit_o]) r_credits++;
    if (tx_phy[link_pkg::tx_b_credit_o]) b_credits++;
    if (r_credits > r_pops || b_credits > b_pops) begin
      report_failure("Credit bit on tx_phy without a matching user handshake");
    end
    if (user_rvalid && user_rready) begin
      if (r_data_exp.size() == 0) report_failure("R response popped that was never injected");
      else begin
        check_equal("user_rdata", 64'(user_rdata), 64'(r_data_exp.pop_front()));
        check_equal("user_rresp", 64'(user_rresp), 64'(r_resp_exp.pop_front()));
      end
      r_pops++;
    end
    if (user_bvalid && user_bready) begin
      if (b_exp.size() == 0) report_failure("B response popped that was never injected");
      else check_equal("user_bresp", 64'(user_bresp), 64'(b_exp.pop_front()));
      b_pops++;
    end
    if (stim_on && r_inj < n_resp && r_inj < r_depth + r_credits && random_bit()) begin
      rp.data = $random(seed);
      rp.resp = 2'($random(seed));
      word[link_pkg::rx_r_push_o] = 1'b1;
      word[link_pkg::rx_r_data_o +: $bits(rp)] = rp;
      r_data_exp.push_back(rp.data);
      r_resp_exp.push_back(rp.resp);
      r_inj++;
    end
    if (stim_on && b_inj < n_resp && b_inj < b_depth + b_credits && random_bit()) begin
      word[link_pkg::rx_b_push_o] = 1'b1;
      word[link_pkg::rx_b_data_o +: 2] = 2'($random(seed));
      b_exp.push_back(word[link_pkg::rx_b_data_o +: 2]);
      b_inj++;
    end
    rx_phy <= word;
    // Accepted requests, then new valids held until ready
    if (user_arvalid && user_arready) begin
      ar_exp.push_back(user_araddr);
      acc[0]++;
    end
    if (user_awvalid && user_awready) begin
      aw_exp.push_back(user_awaddr);
      acc[1]++;
    end
    if (user_wvalid && user_wready) begin
      w_exp.push_back({user_wstrb, user_wdata});
      acc[2]++;
    end
    if (!user_arvalid || user_arready) begin
      user_arvalid <= stim_on && acc[0] < n_req && random_bit();
      user_araddr  <= $random(seed);
    end
    if (!user_awvalid || user_awready) begin
      user_awvalid <= stim_on && acc[1] < n_req && random_bit();
      user_awaddr  <= $random(seed);
    end
    if (!user_wvalid || user_wready) begin
      user_wvalid <= stim_on && acc[2] < n_req && random_bit();
      user_wdata  <= $random(seed);
      user_wstrb  <= 4'($random(seed));
    end
    user_rready <= stim_on && random_bit();
    user_bready <= stim_on && random_bit();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Run control

  initial begin : run_control
    rst = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_ar_credit = link_pkg::credit_t'(init_credit_val[0]);
    init_aw_credit = link_pkg::credit_t'(init_credit_val[1]);
    init_w_credit = link_pkg::credit_t'(init_credit_val[2]);
    rx_phy = '0;
    user_araddr = '0;
    user_arvalid = 1'b0;
    user_awaddr = '0;
    user_awvalid = 1'b0;
    user_wdata = '0;
    user_wstrb = '0;
    user_wvalid = 1'b0;
    user_rready = 1'b0;
    user_bready = 1'b0;
    stim_on = 1'b0;
    hold_credit = 1'b1;
    repeat (4) @(posedge clk_wr);
    rst <= 1'b0;
    repeat (6) @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    stim_on <= 1'b1;
    // Far end keeps its credits, so only the initial ones can be used
    repeat (hold_cycles) @(posedge clk_wr);
    @(negedge clk_wr);
    for (int i = 0; i < 3; i++) begin
      check_equal("pushes with credits withheld", 64'(pushes[i]), 64'(init_credit_val[i]));
    end
    @(posedge clk_wr);
    hold_credit <= 1'b0;
    while (!run_complete()) @(negedge clk_wr);
    // Credit bits of the last pops are still on their way
    repeat (credit_lag) @(negedge clk_wr);
    check_equal("R credit bits", 64'(r_credits), 64'(r_pops));
    check_equal("B credit bits", 64'(b_credits), 64'(b_pops));
    $display("*** PASSED ***");
    $finish;
  end

  initial begin : watchdog
    repeat (limit_cycles) @(posedge clk_wr);
    report_failure("Watchdog timeout, traffic did not complete in time");
  end

endmodule

//--- hdl/axi_lite_link_master.sv
/*
  AXI-lite master, 32-bit address and data, carried over a credit based
  logic link. AR, AW and W leave through transmitters, R and B come back
  through receive buffers, and the framer forms the link words.
*/

`timescale 1ns/10ps

module axi_lite_link_master #(
  parameter int R_DEPTH = 8,
  parameter int B_DEPTH = 8
) (
  input  logic                                  clk_wr,
  input  logic                                  rst,

  input  logic                                  tx_online,
  input  logic                                  rx_online,
  input  link_pkg::credit_t                     init_ar_credit,
  input  link_pkg::credit_t                     init_aw_credit,
  input  link_pkg::credit_t                     init_w_credit,

  output logic [link_pkg::tx_word_w-1:0]        tx_phy,
  input  logic [link_pkg::rx_word_w-1:0]        rx_phy,

  input  logic [axi_lite_pkg::addr_w-1:0]       user_araddr,
  input  logic                                  user_arvalid,
  output logic                                  user_arready,

  input  logic [axi_lite_pkg::addr_w-1:0]       user_awaddr,
  input  logic                                  user_awvalid,
  output logic                                  user_awready,

  input  logic [axi_lite_pkg::data_w-1:0]       user_wdata,
  input  logic [axi_lite_pkg::strb_w-1:0]       user_wstrb,
  input  logic                                  user_wvalid,
  output logic                                  user_wready,

  output logic [axi_lite_pkg::data_w-1:0]       user_rdata,
  output logic [axi_lite_pkg::resp_w-1:0]       user_rresp,
  output logic                                  user_rvalid,
  input  logic                                  user_rready,

  output logic [axi_lite_pkg::resp_w-1:0]       user_bresp,
  output logic                                  user_bvalid,
  input  logic                                  user_bready
);

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect

  logic                      ar_push;
  logic                      aw_push;
  logic                      w_push;
  logic                      r_push;
  logic                      b_push;
  logic                      ar_credit;
  logic                      aw_credit;
  logic                      w_credit;
  logic                      r_credit;
  logic                      b_credit;
  axi_lite_pkg::ar_payload_t ar_payload;
  axi_lite_pkg::aw_payload_t aw_payload;
  axi_lite_pkg::w_payload_t  w_payload;
  axi_lite_pkg::w_payload_t  w_user_payload;
  axi_lite_pkg::r_payload_t  r_payload;
  axi_lite_pkg::r_payload_t  r_user_payload;
  axi_lite_pkg::b_payload_t  b_payload;

  // AXI fields to and from payloads
  assign w_user_payload = {user_wstrb, user_wdata};
  assign user_rdata     = r_user_payload.data;
  assign user_rresp     = r_user_payload.resp;

  ////////////////////////////////////////////////////////////////////////////
  // Request transmitters

  ll_transmit #(.payload_t(axi_lite_pkg::ar_payload_t)) ll_transmit_ar (
    .clk_wr(clk_wr), .rst(rst), .tx_online(tx_online), .rx_online(rx_online),
    .init_credit(init_ar_credit),
    .user_valid(user_arvalid), .user_ready(user_arready), .user_data(user_araddr),
    .rx_credit(ar_credit), .tx_push(ar_push), .tx_data(ar_payload)
  );

  ll_transmit #(.payload_t(axi_lite_pkg::aw_payload_t)) ll_transmit_aw (
    .clk_wr(clk_wr), .rst(rst), .tx_online(tx_online), .rx_online(rx_online),
    .init_credit(init_aw_credit),
    .user_valid(user_awvalid), .user_ready(user_awready), .user_data(user_awaddr),
    .rx_credit(aw_credit), .tx_push(aw_push), .tx_data(aw_payload)
  );

  ll_transmit #(.payload_t(axi_lite_pkg::w_payload_t)) ll_transmit_w (
    .clk_wr(clk_wr), .rst(rst), .tx_online(tx_online), .rx_online(rx_online),
    .init_credit(init_w_credit),
    .user_valid(user_wvalid), .user_ready(user_wready), .user_data(w_user_payload),
    .rx_credit(w_credit), .tx_push(w_push), .tx_data(w_payload)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response receivers

  ll_receive #(.payload_t(axi_lite_pkg::r_payload_t), .DEPTH(R_DEPTH)) ll_receive_r (
    .clk_wr(clk_wr), .rst(rst), .rx_push(r_push), .rx_data(r_payload),
    .user_valid(user_rvalid), .user_ready(user_rready), .user_data(r_user_payload),
    .tx_credit(r_credit)
  );

  ll_receive #(.payload_t(axi_lite_pkg::b_payload_t), .DEPTH(B_DEPTH)) ll_receive_b (
    .clk_wr(clk_wr), .rst(rst), .rx_push(b_push), .rx_data(b_payload),
    .user_valid(user_bvalid), .user_ready(user_bready), .user_data(user_bresp),
    .tx_credit(b_credit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Link words

  phy_framer phy_framer_i (
    .clk_wr(clk_wr), .rst(rst), .tx_phy(tx_phy), .rx_phy(rx_phy),
    .ar_push(ar_push), .ar_payload(ar_payload),
    .aw_push(aw_push), .aw_payload(aw_payload),
    .w_push(w_push), .w_payload(w_payload),
    .ar_credit(ar_credit), .aw_credit(aw_credit), .w_credit(w_credit),
    .r_push(r_push), .r_payload(r_payload),
    .b_push(b_push), .b_payload(b_payload),
    .r_credit(r_credit), .b_credit(b_credit)
  );

endmodule

//--- hdl/phy_framer.sv
/*
  Packs the request pushes and returned credits into the transmit word and
  splits the receive word into response pushes and request credits.
  One register stage in each direction. Field positions come from link_pkg.
*/

`timescale 1ns/10ps

module phy_framer (
  input  logic                               clk_wr,
  input  logic                               rst,

  output logic [link_pkg::tx_word_w-1:0]     tx_phy,
  input  logic [link_pkg::rx_word_w-1:0]     rx_phy,

  // Requests from the transmitters
  input  logic                               ar_push,
  input  axi_lite_pkg::ar_payload_t          ar_payload,
  input  logic                               aw_push,
  input  axi_lite_pkg::aw_payload_t          aw_payload,
  input  logic                               w_push,
  input  axi_lite_pkg::w_payload_t           w_payload,

  output logic                               ar_credit,
  output logic                               aw_credit,
  output logic                               w_credit,

  // Responses to the receivers
  output logic                               r_push,
  output axi_lite_pkg::r_payload_t           r_payload,
  output logic                               b_push,
  output axi_lite_pkg::b_payload_t           b_payload,

  input  logic                               r_credit,
  input  logic                               b_credit
);

  logic [link_pkg::tx_word_w-1:0] tx_next;
  logic [link_pkg::rx_word_w-1:0] rx_q;

  always_comb begin
    tx_next = '0;
    tx_next[link_pkg::tx_ar_push_o] = ar_push;
    tx_next[link_pkg::tx_ar_data_o +: $bits(axi_lite_pkg::ar_payload_t)] = ar_payload;
    tx_next[link_pkg::tx_aw_push_o] = aw_push;
    tx_next[link_pkg::tx_aw_data_o +: $bits(axi_lite_pkg::aw_payload_t)] = aw_payload;
    tx_next[link_pkg::tx_w_push_o] = w_push;
    tx_next[link_pkg::tx_w_data_o +: $bits(axi_lite_pkg::w_payload_t)] = w_payload;
    tx_next[link_pkg::tx_r_credit_o] = r_credit;
    tx_next[link_pkg::tx_b_credit_o] = b_credit;
  end

  // Both words clear on reset so that no stray pulse reaches either side
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy <= '0;
      rx_q   <= '0;
    end else begin
      tx_phy <= tx_next;
      rx_q   <= rx_phy;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive word fields

  assign r_push    = rx_q[link_pkg::rx_r_push_o];
  assign r_payload = rx_q[link_pkg::rx_r_data_o +: $bits(axi_lite_pkg::r_payload_t)];
  assign b_push    = rx_q[link_pkg::rx_b_push_o];
  assign b_payload = rx_q[link_pkg::rx_b_data_o +: $bits(axi_lite_pkg::b_payload_t)];
  assign ar_credit = rx_q[link_pkg::rx_ar_credit_o];
  assign aw_credit = rx_q[link_pkg::rx_aw_credit_o];
  assign w_credit  = rx_q[link_pkg::rx_w_credit_o];

endmodule

//--- hdl/ll_receive.sv
/*
  Response receive buffer. The far end pushes entries into a FIFO of
  DEPTH entries and the user pops them with valid/ready. Each pop sends
  one credit pulse back over the link. DEPTH is a power of two, at least 2.
*/

`timescale 1ns/10ps

module ll_receive #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk_wr,
  input  logic     rst,

  // Link side
  input  logic     rx_push,
  input  payload_t rx_data,

  // User side
  output logic     user_valid,
  input  logic     user_ready,
  output payload_t user_data,

  output logic     tx_credit
);

  localparam int ptr_w = $clog2(DEPTH);

  // Extra top bit tells full from empty
  typedef logic [ptr_w:0] ptr_t;

  payload_t mem [DEPTH];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  logic     empty;
  logic     pop;

  assign empty      = (wr_ptr_q == rd_ptr_q);
  assign user_valid = ~empty;
  assign user_data  = mem[rd_ptr_q[ptr_w-1:0]];
  assign pop        = user_valid & user_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Storage

  // Credits at the far end keep pushes within DEPTH
  always_ff @(posedge clk_wr) begin
    if (rx_push) begin
      mem[wr_ptr_q[ptr_w-1:0]] <= rx_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and credit return

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr_q <= '0;
    end else if (rx_push) begin
      wr_ptr_q <= wr_ptr_q + ptr_t'(1);
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rd_ptr_q <= '0;
    end else if (pop) begin
      rd_ptr_q <= rd_ptr_q + ptr_t'(1);
    end
  end

  // One pulse per popped entry, the cycle after the pop
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_credit <= 1'b0;
    end else begin
      tx_credit <= pop;
    end
  end

endmodule

//--- hdl/ll_transmit.sv
/*
  Request channel transmitter with a single entry and credit flow control.
  The user loads the entry with a valid/ready handshake. The entry goes
  out as a one-cycle push once the far end has credit and the link is up.
*/

`timescale 1ns/10ps

module ll_transmit #(
  parameter type payload_t = logic [7:0]
) (
  input  logic              clk_wr,
  input  logic              rst,

  input  logic              tx_online,
  input  logic              rx_online,
  input  link_pkg::credit_t init_credit,

  // User side
  input  logic              user_valid,
  output logic              user_ready,
  input  payload_t          user_data,

  // Link side
  input  logic              rx_credit,
  output logic              tx_push,
  output payload_t          tx_data
);

  logic              entry_full_q;
  payload_t          entry_q;
  link_pkg::credit_t credit_q;
  logic              link_up;
  logic              launch;

  assign link_up    = tx_online & rx_online;
  assign user_ready = ~entry_full_q;

  // No second push while the first one is still on the wire
  assign launch = entry_full_q & ~tx_push & (credit_q != '0) & link_up;

  // Entry is held until the push has gone out
  assign tx_data = entry_q;

  always_ff @(posedge clk_wr) begin
    if (user_valid && user_ready) begin
      entry_q <= user_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Entry state and push

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      entry_full_q <= 1'b0;
      tx_push      <= 1'b0;
    end else begin
      tx_push <= launch;
      if (tx_push) begin
        entry_full_q <= 1'b0;
      end else if (user_valid && user_ready) begin
        entry_full_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      credit_q <= '0;
    end else if (!link_up) begin
      credit_q <= init_credit;
    end else begin
      case ({rx_credit, launch})
        2'b10:   credit_q <= credit_q + link_pkg::credit_t'(1);
        2'b01:   credit_q <= credit_q - link_pkg::credit_t'(1);
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

//--- hdl/link_pkg.sv
/*
  Link word widths, field offsets and the credit counter type.
  Offsets count up from bit 0 of each word in the order of the fields.
*/

package link_pkg;

  parameter int credit_w = 8;

  typedef logic [credit_w-1:0] credit_t;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit word, master to far end

  parameter int tx_ar_push_o   = 0;
  parameter int tx_ar_data_o   = tx_ar_push_o + 1;
  parameter int tx_aw_push_o   = tx_ar_data_o + $bits(axi_lite_pkg::ar_payload_t);
  parameter int tx_aw_data_o   = tx_aw_push_o + 1;
  parameter int tx_w_push_o    = tx_aw_data_o + $bits(axi_lite_pkg::aw_payload_t);
  parameter int tx_w_data_o    = tx_w_push_o + 1;
  parameter int tx_r_credit_o  = tx_w_data_o + $bits(axi_lite_pkg::w_payload_t);
  parameter int tx_b_credit_o  = tx_r_credit_o + 1;
  // 105 bits
  parameter int tx_word_w      = tx_b_credit_o + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Receive word, far end to master

  parameter int rx_r_push_o    = 0;
  parameter int rx_r_data_o    = rx_r_push_o + 1;
  parameter int rx_b_push_o    = rx_r_data_o + $bits(axi_lite_pkg::r_payload_t);
  parameter int rx_b_data_o    = rx_b_push_o + 1;
  parameter int rx_ar_credit_o = rx_b_data_o + $bits(axi_lite_pkg::b_payload_t);
  parameter int rx_aw_credit_o = rx_ar_credit_o + 1;
  parameter int rx_w_credit_o  = rx_aw_credit_o + 1;
  // 41 bits
  parameter int rx_word_w      = rx_w_credit_o + 1;

endpackage

//--- hdl/axi_lite_pkg.sv
/*
  AXI-lite field widths and the payload types of the five channels.
  Shared by the link modules and the top level through scoped names.
*/

package axi_lite_pkg;

  parameter int addr_w = 32;
  parameter int data_w = 32;
  parameter int strb_w = 4;
  parameter int resp_w = 2;

  // Read and write address channels carry the address only
  typedef logic [addr_w-1:0] ar_payload_t;
  typedef logic [addr_w-1:0] aw_payload_t;

  // Strobe sits above data, 36 bits
  typedef struct packed {
    logic [strb_w-1:0] strb;
    logic [data_w-1:0] data;
  } w_payload_t;

  // Data above response, 34 bits
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [resp_w-1:0] resp;
  } r_payload_t;

  typedef logic [resp_w-1:0] b_payload_t;

endpackage
